// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - include_dirs:
      - design
    files:
      - design/decode_pkg.sv
      - design/instr_field_decoder.sv
      - design/alu_op_decoder.sv
      - design/system_decoder.sv
      - design/decode_ctrl_fsm.sv
      - design/dispatch_credit_counter.sv
      - design/decode_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/decode_stage_checker.sv
      - tests/decode_stage_tb.sv

// ==== design/alu_op_decoder.sv ====
`timescale 1ns/10ps

module alu_op_decoder import decode_pkg::*; (
  input  word_t   instr_i,
  output alu_op_e alu_op_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       op_imm;
  logic       op_reg;
  logic       alt;
  logic       sr;
  logic       add_sub;
  logic       is_sll;
  logic       is_add;
  logic       is_and;
  logic       is_or;
  logic       is_xor;
  logic       is_slt;
  logic       is_sltu;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign op_imm = (opcode == OP_IMMED);
  assign op_reg = (opcode == OP_REGREG);
  // bit 30 picks arithmetic shift and subtract
  assign alt    = instr_i[30];

  // funct3 matches for either immediate or register form
  assign sr      = (op_imm || op_reg) && (funct3 == F3_SR);
  assign add_sub = op_reg && (funct3 == F3_ADD);
  assign is_sll  = (op_imm || op_reg) && (funct3 == F3_SLL);
  assign is_and  = (op_imm || op_reg) && (funct3 == F3_AND);
  assign is_or   = (op_imm || op_reg) && (funct3 == F3_OR);
  assign is_xor  = (op_imm || op_reg) && (funct3 == F3_XOR);
  assign is_slt  = (op_imm || op_reg) && (funct3 == F3_SLT);
  assign is_sltu = (op_imm || op_reg) && (funct3 == F3_SLTU);

  // address generation also goes through the adder
  assign is_add = (op_imm && funct3 == F3_ADD) || (add_sub && !alt) ||
                  (opcode == OP_LOAD) || (opcode == OP_STORE) ||
                  (opcode == OP_AUIPC);

  always_comb begin
    if (is_sll) begin
      alu_op_o = ALU_SLL;
    end else if (sr && alt) begin
      alu_op_o = ALU_SRA;
    end else if (sr) begin
      alu_op_o = ALU_SRL;
    end else if (is_add) begin
      alu_op_o = ALU_ADD;
    end else if (add_sub) begin
      alu_op_o = ALU_SUB;
    end else if (is_and) begin
      alu_op_o = ALU_AND;
    end else if (is_or) begin
      alu_op_o = ALU_OR;
    end else if (is_xor) begin
      alu_op_o = ALU_XOR;
    end else if (is_slt) begin
      alu_op_o = ALU_SLT;
    end else if (is_sltu) begin
      alu_op_o = ALU_SLTU;
    end else begin
      alu_op_o = ALU_ADD;
    end
  end

endmodule

// ==== design/decode_ctrl_fsm.sv ====
`timescale 1ns/10ps
`include "decode_macros.svh"

module decode_ctrl_fsm import decode_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  accept_i,
  input  word_t instr_i,
  input  logic  irq_i,
  output logic  accept_en_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        halt_hit;
  logic        wfi_hit;

  assign halt_hit = `DEC_HALT_EN && (instr_i == `DEC_HALT_INSN);
  assign wfi_hit  = (instr_i[6:0] == OP_SYSTEM) && (instr_i[14:12] == SYS_PRIV) &&
                    (instr_i[31:20] == PRIV_WFI);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RUN: begin
        if (accept_i && halt_hit) begin
          state_d = ST_HALTED;
        end else if (accept_i && wfi_hit) begin
          state_d = ST_WAIT_IRQ;
        end
      end
      ST_WAIT_IRQ: begin
        if (irq_i) begin
          state_d = ST_RUN;
        end
      end
      // only reset leaves halt
      default: state_d = state_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign accept_en_o = (state_q == ST_RUN);

endmodule

// ==== design/decode_macros.svh ====
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// instruction and data word width
`define DEC_XLEN 32

// register file index width
`define DEC_REG_IDX_W 5

// free back-end slots out of reset
`define DEC_CREDITS 4

// wide enough to hold DEC_CREDITS itself
`define DEC_CREDIT_W 3

// the "j ." self loop, used as the stop marker in unit tests
`define DEC_HALT_INSN 32'h0000_006f

// set to 1'b0 when a self loop must be treated as ordinary code
`define DEC_HALT_EN 1'b1

`endif

// ==== design/decode_pkg.sv ====
`include "decode_macros.svh"

package decode_pkg;

  typedef logic [`DEC_XLEN-1:0]      word_t;
  typedef logic [`DEC_REG_IDX_W-1:0] reg_idx_t;

  // rv32 major opcodes
  typedef enum logic [6:0] {
    OP_LUI      = 7'b0110111,
    OP_AUIPC    = 7'b0010111,
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_LOAD     = 7'b0000011,
    OP_STORE    = 7'b0100011,
    OP_IMMED    = 7'b0010011,
    OP_REGREG   = 7'b0110011,
    OP_MISCMEM  = 7'b0001111,
    OP_SYSTEM   = 7'b1110011,
    OP_LOAD_FP  = 7'b0000111,
    OP_STORE_FP = 7'b0100111,
    OP_VECTOR   = 7'b1010111
  } opcode_e;

  // funct3 shared by IMMED and REGREG
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_e;

  typedef enum logic [2:0] {
    SYS_PRIV   = 3'b000,
    SYS_CSRRW  = 3'b001,
    SYS_CSRRS  = 3'b010,
    SYS_CSRRC  = 3'b011,
    SYS_CSRRWI = 3'b101,
    SYS_CSRRSI = 3'b110,
    SYS_CSRRCI = 3'b111
  } sys_f3_e;

  typedef enum logic [2:0] {
    MEM_FENCE  = 3'b000,
    MEM_FENCEI = 3'b001
  } miscmem_f3_e;

  // imm11_00 of a PRIV instruction
  typedef enum logic [11:0] {
    PRIV_ECALL  = 12'h000,
    PRIV_EBREAK = 12'h001,
    PRIV_WFI    = 12'h105,
    PRIV_MRET   = 12'h302
  } priv_imm_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
  } alu_op_e;

  typedef enum logic [1:0] {
    UNIT_ARITH, UNIT_LOADSTORE, UNIT_MUL, UNIT_DIV
  } unit_e;

  typedef enum logic [2:0] {
    WSRC_LOAD, WSRC_JUMP, WSRC_LUI, WSRC_ALU, WSRC_CSR
  } w_src_e;

  typedef enum logic [1:0] {
    SIGN_SIGNED, SIGN_UNSIGNED, SIGN_SIGNED_UNSIGNED
  } sign_e;

  typedef enum logic [1:0] {
    ST_RUN, ST_HALTED, ST_WAIT_IRQ
  } ctrl_state_e;

  typedef struct packed {
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    word_t       imm;
    logic        imm_shamt_sel;
    logic [1:0]  source_a_sel;
    logic [1:0]  source_b_sel;
    w_src_e      w_src;
    logic        wen;
    unit_e       unit;
    sign_e       sign;
    logic        high_low_sel;
    logic        div_type;
    logic        branch;
    logic        jump;
    logic        j_sel;
    logic        lui_instr;
    logic        illegal;
  } field_bundle_t;

  typedef struct packed {
    logic        csr_swap;
    logic        csr_set;
    logic        csr_clr;
    logic        csr_imm;
    logic [11:0] csr_addr;
    word_t       zimm;
    logic        ret_insn;
    logic        ecall_insn;
    logic        breakpoint;
    logic        wfi;
    logic        ifence;
  } sys_bundle_t;

  typedef struct packed {
    field_bundle_t fields;
    sys_bundle_t   sys;
    alu_op_e       alu_op;
  } dispatch_t;

endpackage

// ==== design/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage import decode_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      instr_valid_i,
  input  word_t     instr_i,
  input  logic      credit_return_i,
  input  logic      irq_i,
  output logic      instr_ready_o,
  output logic      dispatch_valid_o,
  output dispatch_t dispatch_o
);

  field_bundle_t fields;
  sys_bundle_t   sys;
  alu_op_e       alu_op;
  logic          accept_en;
  logic          has_credit;
  logic          accept;
  dispatch_t     dispatch_d;
  dispatch_t     dispatch_q;
  logic          dispatch_valid_q;

  instr_field_decoder field_dec_i (
    .instr_i  (instr_i),
    .fields_o (fields)
  );

  alu_op_decoder alu_dec_i (
    .instr_i  (instr_i),
    .alu_op_o (alu_op)
  );

  system_decoder sys_dec_i (
    .instr_i (instr_i),
    .sys_o   (sys)
  );

  decode_ctrl_fsm ctrl_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .accept_i    (accept),
    .instr_i     (instr_i),
    .irq_i       (irq_i),
    .accept_en_o (accept_en)
  );

  dispatch_credit_counter credit_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .accept_i        (accept),
    .credit_return_i (credit_return_i),
    .has_credit_o    (has_credit)
  );

  // ready needs a run state and a free back-end slot
  assign instr_ready_o = accept_en && has_credit;
  assign accept        = instr_valid_i && instr_ready_o;

  always_comb begin
    dispatch_d.fields = fields;
    // csr ops write rd, the other SYSTEM forms do not
    dispatch_d.fields.wen = fields.wen || sys.csr_swap || sys.csr_set || sys.csr_clr;
    dispatch_d.sys    = sys;
    dispatch_d.alu_op = alu_op;
  end

  // payload only loads on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      dispatch_q <= dispatch_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dispatch_valid_q <= 1'b0;
    end else begin
      dispatch_valid_q <= accept;
    end
  end

  assign dispatch_valid_o = dispatch_valid_q;
  assign dispatch_o       = dispatch_q;

endmodule

// ==== design/dispatch_credit_counter.sv ====
`timescale 1ns/10ps
`include "decode_macros.svh"

module dispatch_credit_counter (
  input  logic clk,
  input  logic rst_n_i,
  input  logic accept_i,
  input  logic credit_return_i,
  output logic has_credit_o
);

  logic [`DEC_CREDIT_W-1:0] credits_q;
  logic                     at_max;

  assign at_max = (credits_q == `DEC_CREDIT_W'(`DEC_CREDITS));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      credits_q <= `DEC_CREDIT_W'(`DEC_CREDITS);
    end else begin
      case ({accept_i, credit_return_i})
        2'b10: credits_q <= credits_q - 1'b1;
        // a stray return at full count is dropped
        2'b01: if (!at_max) credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  assign has_credit_o = (credits_q != '0);

endmodule

// ==== design/instr_field_decoder.sv ====
`timescale 1ns/10ps

module instr_field_decoder import decode_pkg::*; (
  input  word_t         instr_i,
  output field_bundle_t fields_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_muldiv;

  assign opcode    = opcode_e'(instr_i[6:0]);
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign is_muldiv = (opcode == OP_REGREG) && (funct7 == 7'b000_0001);

  always_comb begin
    fields_o.rs1 = instr_i[19:15];
    fields_o.rs2 = instr_i[24:20];
    fields_o.rd  = instr_i[11:7];

    // immediate format follows the opcode
    case (opcode)
      OP_IMMED, OP_LOAD, OP_JALR, OP_SYSTEM:
        fields_o.imm = {{20{instr_i[31]}}, instr_i[31:20]};
      OP_STORE:
        fields_o.imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      OP_BRANCH:
        fields_o.imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
      OP_LUI, OP_AUIPC:
        fields_o.imm = {instr_i[31:12], 12'b0};
      OP_JAL:
        fields_o.imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
      default:
        fields_o.imm = '0;
    endcase

    fields_o.imm_shamt_sel = (opcode == OP_IMMED) &&
                             (funct3 == F3_SLL || funct3 == F3_SR);

    // operand a: rs1, store base, or pc
    case (opcode)
      OP_REGREG, OP_IMMED, OP_LOAD,
      OP_BRANCH, OP_JALR, OP_SYSTEM: fields_o.source_a_sel = 2'd0;
      OP_STORE:                      fields_o.source_a_sel = 2'd1;
      default:                       fields_o.source_a_sel = 2'd2;
    endcase

    case (opcode)
      OP_STORE:           fields_o.source_b_sel = 2'd0;
      OP_REGREG:          fields_o.source_b_sel = 2'd1;
      OP_IMMED, OP_LOAD:  fields_o.source_b_sel = 2'd2;
      OP_AUIPC:           fields_o.source_b_sel = 2'd3;
      default:            fields_o.source_b_sel = 2'd1;
    endcase

    case (opcode)
      OP_JAL, OP_JALR:                fields_o.w_src = WSRC_JUMP;
      OP_LUI:                         fields_o.w_src = WSRC_LUI;
      OP_IMMED, OP_AUIPC, OP_REGREG:  fields_o.w_src = WSRC_ALU;
      OP_SYSTEM:                      fields_o.w_src = WSRC_CSR;
      default:                        fields_o.w_src = WSRC_LOAD;
    endcase

    // SYSTEM write enable comes from the csr op in the top level
    case (opcode)
      OP_IMMED, OP_LUI, OP_AUIPC, OP_REGREG,
      OP_JAL, OP_JALR, OP_LOAD: fields_o.wen = 1'b1;
      default:                  fields_o.wen = 1'b0;
    endcase

    if (is_muldiv) begin
      fields_o.unit = funct3[2] ? UNIT_DIV : UNIT_MUL;
    end else if (opcode == OP_LOAD || opcode == OP_STORE) begin
      fields_o.unit = UNIT_LOADSTORE;
    end else begin
      fields_o.unit = UNIT_ARITH;
    end

    case (funct3)
      3'b011, 3'b101, 3'b111: fields_o.sign = SIGN_UNSIGNED;
      3'b010:                 fields_o.sign = SIGN_SIGNED_UNSIGNED;
      default:                fields_o.sign = SIGN_SIGNED;
    endcase

    // upper product half for mulh*, divide rather than remainder
    fields_o.high_low_sel = |funct3[1:0];
    fields_o.div_type     = is_muldiv && funct3[2] && !funct3[1];

    fields_o.branch    = (opcode == OP_BRANCH);
    fields_o.jump      = (opcode == OP_JAL) || (opcode == OP_JALR);
    fields_o.j_sel     = (opcode == OP_JAL);
    fields_o.lui_instr = (opcode == OP_LUI);

    case (opcode)
      OP_REGREG:
        fields_o.illegal = funct7[0] && (funct7 != 7'b000_0001);
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
      OP_STORE, OP_IMMED, OP_SYSTEM, OP_MISCMEM:
        fields_o.illegal = 1'b0;
      default:
        fields_o.illegal = 1'b1;
    endcase
  end

endmodule

// ==== design/system_decoder.sv ====
`timescale 1ns/10ps

module system_decoder import decode_pkg::*; (
  input  word_t       instr_i,
  output sys_bundle_t sys_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [11:0] imm11_00;

  assign opcode   = opcode_e'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign imm11_00 = instr_i[31:20];

  always_comb begin
    sys_o = '0;
    sys_o.csr_addr = imm11_00;

    if (opcode == OP_SYSTEM) begin
      // uimm field sits where rs1 would be
      sys_o.zimm = word_t'(instr_i[19:15]);

      case (funct3)
        SYS_CSRRW: begin
          sys_o.csr_swap = 1'b1;
        end
        SYS_CSRRS: begin
          sys_o.csr_set = 1'b1;
        end
        SYS_CSRRC: begin
          sys_o.csr_clr = 1'b1;
        end
        SYS_CSRRWI: begin
          sys_o.csr_swap = 1'b1;
          sys_o.csr_imm  = 1'b1;
        end
        SYS_CSRRSI: begin
          sys_o.csr_set = 1'b1;
          sys_o.csr_imm = 1'b1;
        end
        SYS_CSRRCI: begin
          sys_o.csr_clr = 1'b1;
          sys_o.csr_imm = 1'b1;
        end
        SYS_PRIV: begin
          sys_o.ret_insn   = (imm11_00 == PRIV_MRET);
          sys_o.ecall_insn = (imm11_00 == PRIV_ECALL);
          sys_o.breakpoint = (imm11_00 == PRIV_EBREAK);
          sys_o.wfi        = (imm11_00 == PRIV_WFI);
        end
        default: begin
          sys_o.csr_swap = 1'b0;
        end
      endcase
    end

    sys_o.ifence = (opcode == OP_MISCMEM) && (funct3 == MEM_FENCEI);
  end

endmodule

// ==== sim.f ====
+incdir+design
design/decode_pkg.sv
design/instr_field_decoder.sv
design/alu_op_decoder.sv
design/system_decoder.sv
design/decode_ctrl_fsm.sv
design/dispatch_credit_counter.sv
design/decode_stage.sv
tests/decode_stage_checker.sv
tests/decode_stage_tb.sv

// ==== tests/decode_stage_checker.sv ====
`timescale 1ns/10ps
`include "decode_macros.svh"

module decode_stage_checker (
  input logic clk,
  input logic rst_n_i,
  input logic instr_valid_i,
  input logic instr_ready_i,
  input logic credit_return_i,
  input logic dispatch_valid_i
);

  logic                     accept;
  logic                     seen_accept_q;
  logic [`DEC_CREDIT_W-1:0] free_q;
  int                       violations = 0;

  // handshake as seen on the fetch-side ports
  assign accept = instr_valid_i && instr_ready_i;

  // goes high at the first accept after reset
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      seen_accept_q <= 1'b0;
    end else if (accept) begin
      seen_accept_q <= 1'b1;
    end
  end

  // free back-end slots, tracked from port traffic
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      free_q <= `DEC_CREDIT_W'(`DEC_CREDITS);
    end else if (accept && !credit_return_i) begin
      free_q <= free_q - 1'b1;
    end else if (!accept && credit_return_i &&
                 free_q != `DEC_CREDIT_W'(`DEC_CREDITS)) begin
      free_q <= free_q + 1'b1;
    end
  end

  dispatch_follows_accept: assert property (
    @(posedge clk) disable iff (!rst_n_i) accept |=> dispatch_valid_i)
    else begin
      $error("dispatch_valid_o did not follow an accept by one cycle");
      violations = violations + 1;
    end

  no_dispatch_without_accept: assert property (
    @(posedge clk) disable iff (!rst_n_i) !accept |=> !dispatch_valid_i)
    else begin
      $error("dispatch_valid_o high without an accept in the cycle before");
      violations = violations + 1;
    end

  ready_needs_credit: assert property (
    @(posedge clk) disable iff (!rst_n_i) (free_q == '0) |-> !instr_ready_i)
    else begin
      $error("instr_ready_o high with no free back-end slot");
      violations = violations + 1;
    end

  quiet_until_first_accept: assert property (
    @(posedge clk) disable iff (!rst_n_i) !seen_accept_q |-> !dispatch_valid_i)
    else begin
      $error("dispatch_valid_o high before any instruction was accepted");
      violations = violations + 1;
    end

endmodule

bind decode_stage decode_stage_checker decode_checker_i (
  .clk              (clk),
  .rst_n_i          (rst_n_i),
  .instr_valid_i    (instr_valid_i),
  .instr_ready_i    (instr_ready_o),
  .credit_return_i  (credit_return_i),
  .dispatch_valid_i (dispatch_valid_o)
);

// ==== tests/decode_stage_tb.sv ====
`timescale 1ns/10ps
`include "decode_macros.svh"

module decode_stage_tb import decode_pkg::*; ();

  localparam int NUM_INSTR  = 35;
  localparam int STEP_LIMIT = 20;
  // extra cycles for the fixed waits inside the tests
  localparam int MARGIN     = 100;

  logic        clk;
  logic        rst_n_i;
  logic        instr_valid_i;
  word_t       instr_i;
  logic        credit_return_i;
  logic        irq_i;
  logic        instr_ready_o;
  logic        dispatch_valid_o;
  dispatch_t   dispatch_o;

  dispatch_t   got;
  int          errors;
  int          checks;
  int          tests_run;

  decode_stage decode_stage_i (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .credit_return_i  (credit_return_i),
    .irq_i            (irq_i),
    .instr_ready_o    (instr_ready_o),
    .dispatch_valid_o (dispatch_valid_o),
    .dispatch_o       (dispatch_o)
  );

  always #5 clk = ~clk;

  // instruction encoders, standard rv32 layouts
  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("** Error: %s expected 0x%08h, got 0x%08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    $display("%s finished with %0d errors", name, errors - errors_before);
  endtask

  task automatic give_credit(input int n);
    repeat (n) begin
      @(negedge clk);
      credit_return_i = 1'b1;
    end
    @(negedge clk);
    credit_return_i = 1'b0;
  endtask

  // one accept, then the captured bundle lands in got
  task automatic issue(input word_t instr);
    int wait_cycles;
    wait_cycles = 0;
    @(negedge clk);
    instr_valid_i = 1'b1;
    instr_i       = instr;
    while (!instr_ready_o && wait_cycles < STEP_LIMIT) begin
      @(negedge clk);
      wait_cycles++;
    end
    checks++;
    assert (instr_ready_o) else begin
      $display("instruction 0x%08h was not accepted within %0d cycles", instr, STEP_LIMIT);
      errors++;
    end
    @(negedge clk);
    instr_valid_i = 1'b0;
    wait_cycles   = 0;
    while (!dispatch_valid_o && wait_cycles < STEP_LIMIT) begin
      @(negedge clk);
      wait_cycles++;
    end
    checks++;
    assert (dispatch_valid_o) else begin
      $display("no dispatch came out for instruction 0x%08h", instr);
      errors++;
    end
    got = dispatch_o;
  endtask

  task automatic issue_and_return(input word_t instr);
    issue(instr);
    give_credit(1);
  endtask

  task automatic expect_core(input alu_op_e alu, input unit_e unit, input w_src_e wsrc,
                             input logic wen);
    check_val("alu_op", alu, got.alu_op);
    check_val("unit", unit, got.fields.unit);
    check_val("wen", wen, got.fields.wen);
    // w_src only matters when rd is written
    if (wen) begin
      check_val("w_src", wsrc, got.fields.w_src);
    end
  endtask

  // a: 0 rs1, 1 store base, 2 pc
  task automatic expect_operands(input logic [1:0] a_sel, input logic [1:0] b_sel);
    check_val("source_a_sel", a_sel, got.fields.source_a_sel);
    check_val("source_b_sel", b_sel, got.fields.source_b_sel);
  endtask

  task automatic alu_instructions();
    int       err0;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    err0 = errors;
    rs1  = reg_idx_t'($urandom());
    rs2  = reg_idx_t'($urandom());
    rd   = reg_idx_t'($urandom());
    issue_and_return(r_type(7'h00, rs2, rs1, 3'b000, rd));
    expect_core(ALU_ADD, UNIT_ARITH, WSRC_ALU, 1'b1);
    expect_operands(2'd0, 2'd1);
    check_val("rs1,rs2,rd", {rs1, rs2, rd},
              {got.fields.rs1, got.fields.rs2, got.fields.rd});
    issue_and_return(r_type(7'h20, rs2, rs1, 3'b000, rd));
    expect_core(ALU_SUB, UNIT_ARITH, WSRC_ALU, 1'b1);
    issue_and_return(r_type(7'h20, rs2, rs1, 3'b101, rd));
    expect_core(ALU_SRA, UNIT_ARITH, WSRC_ALU, 1'b1);
    check_val("imm_shamt_sel", 0, got.fields.imm_shamt_sel);
    issue_and_return(i_type({7'h20, 5'd7}, rs1, 3'b101, rd, 7'b0010011));
    expect_core(ALU_SRA, UNIT_ARITH, WSRC_ALU, 1'b1);
    check_val("imm_shamt_sel", 1, got.fields.imm_shamt_sel);
    issue_and_return(i_type(12'hfff, rs1, 3'b011, rd, 7'b0010011));
    expect_core(ALU_SLTU, UNIT_ARITH, WSRC_ALU, 1'b1);
    check_val("imm", 32'hffff_ffff, got.fields.imm);
    check_val("rs1,rd", {rs1, rd}, {got.fields.rs1, got.fields.rd});
    issue_and_return(i_type(12'h7f0, rs1, 3'b111, rd, 7'b0010011));
    expect_core(ALU_AND, UNIT_ARITH, WSRC_ALU, 1'b1);
    expect_operands(2'd0, 2'd2);
    check_val("imm", 32'h0000_07f0, got.fields.imm);
    check_val("imm_shamt_sel", 0, got.fields.imm_shamt_sel);
    finish_test("alu_instructions", err0);
  endtask

  task automatic memory_and_control();
    int err0;
    err0 = errors;
    issue_and_return(i_type(12'hff8, 5'd3, 3'b010, 5'd9, 7'b0000011));
    expect_core(ALU_ADD, UNIT_LOADSTORE, WSRC_LOAD, 1'b1);
    expect_operands(2'd0, 2'd2);
    check_val("imm", 32'hffff_fff8, got.fields.imm);
    issue_and_return(s_type(12'h123, 5'd7, 5'd2));
    expect_core(ALU_ADD, UNIT_LOADSTORE, WSRC_LOAD, 1'b0);
    expect_operands(2'd1, 2'd0);
    check_val("imm", 32'h0000_0123, got.fields.imm);
    issue_and_return(b_type(13'h1ff0, 5'd4, 5'd5));
    check_val("imm", 32'hffff_fff0, got.fields.imm);
    check_val("branch,jump,wen", 3'b100,
              {got.fields.branch, got.fields.jump, got.fields.wen});
    issue_and_return({20'habcde, 5'd10, 7'b0110111});
    expect_core(ALU_ADD, UNIT_ARITH, WSRC_LUI, 1'b1);
    check_val("imm", 32'habcd_e000, got.fields.imm);
    check_val("lui_instr", 1, got.fields.lui_instr);
    issue_and_return({20'h12345, 5'd11, 7'b0010111});
    expect_core(ALU_ADD, UNIT_ARITH, WSRC_ALU, 1'b1);
    expect_operands(2'd2, 2'd3);
    check_val("imm", 32'h1234_5000, got.fields.imm);
    issue_and_return(j_type(21'h000800, 5'd1));
    expect_core(ALU_ADD, UNIT_ARITH, WSRC_JUMP, 1'b1);
    check_val("imm", 32'h0000_0800, got.fields.imm);
    check_val("branch,jump,j_sel", 3'b011,
              {got.fields.branch, got.fields.jump, got.fields.j_sel});
    issue_and_return(i_type(12'h004, 5'd6, 3'b000, 5'd1, 7'b1100111));
    expect_core(ALU_ADD, UNIT_ARITH, WSRC_JUMP, 1'b1);
    check_val("imm", 32'h0000_0004, got.fields.imm);
    check_val("jump,j_sel", 2'b10, {got.fields.jump, got.fields.j_sel});
    finish_test("memory_and_control", err0);
  endtask

  task automatic muldiv_routing();
    int err0;
    err0 = errors;
    issue_and_return(r_type(7'h01, 5'd2, 5'd3, 3'b000, 5'd4));
    check_val("unit", UNIT_MUL, got.fields.unit);
    check_val("sign", SIGN_SIGNED, got.fields.sign);
    check_val("high_low_sel", 0, got.fields.high_low_sel);
    issue_and_return(r_type(7'h01, 5'd2, 5'd3, 3'b010, 5'd4));
    check_val("unit", UNIT_MUL, got.fields.unit);
    check_val("sign", SIGN_SIGNED_UNSIGNED, got.fields.sign);
    check_val("high_low_sel", 1, got.fields.high_low_sel);
    issue_and_return(r_type(7'h01, 5'd2, 5'd3, 3'b101, 5'd4));
    check_val("unit", UNIT_DIV, got.fields.unit);
    check_val("sign", SIGN_UNSIGNED, got.fields.sign);
    check_val("div_type", 1, got.fields.div_type);
    issue_and_return(r_type(7'h01, 5'd2, 5'd3, 3'b110, 5'd4));
    check_val("unit", UNIT_DIV, got.fields.unit);
    check_val("sign", SIGN_SIGNED, got.fields.sign);
    check_val("div_type,wen,illegal", 3'b010,
              {got.fields.div_type, got.fields.wen, got.fields.illegal});
    finish_test("muldiv_routing", err0);
  endtask

  task automatic expect_csr(input logic [3:0] swap_set_clr_imm, input logic wen);
    check_val("csr_swap,csr_set,csr_clr,csr_imm", swap_set_clr_imm,
              {got.sys.csr_swap, got.sys.csr_set, got.sys.csr_clr, got.sys.csr_imm});
    check_val("wen", wen, got.fields.wen);
  endtask

  task automatic system_and_illegal();
    int err0;
    err0 = errors;
    issue_and_return(i_type(12'h300, 5'd8, 3'b001, 5'd5, 7'b1110011));
    expect_csr(4'b1000, 1'b1);
    check_val("csr_addr", 12'h300, got.sys.csr_addr);
    check_val("w_src", WSRC_CSR, got.fields.w_src);
    issue_and_return(i_type(12'h341, 5'h15, 3'b110, 5'd6, 7'b1110011));
    expect_csr(4'b0101, 1'b1);
    check_val("csr_addr", 12'h341, got.sys.csr_addr);
    check_val("zimm", 32'h0000_0015, got.sys.zimm);
    issue_and_return(i_type(12'h342, 5'd9, 3'b011, 5'd7, 7'b1110011));
    expect_csr(4'b0010, 1'b1);
    issue_and_return(32'h0000_0073);
    expect_csr(4'b0000, 1'b0);
    check_val("ecall_insn,ret_insn,breakpoint", 3'b100,
              {got.sys.ecall_insn, got.sys.ret_insn, got.sys.breakpoint});
    issue_and_return(32'h3020_0073);
    expect_csr(4'b0000, 1'b0);
    check_val("ecall_insn,ret_insn,breakpoint", 3'b010,
              {got.sys.ecall_insn, got.sys.ret_insn, got.sys.breakpoint});
    issue_and_return(32'h0010_0073);
    expect_csr(4'b0000, 1'b0);
    check_val("ecall_insn,ret_insn,breakpoint", 3'b001,
              {got.sys.ecall_insn, got.sys.ret_insn, got.sys.breakpoint});
    issue_and_return(32'h0000_100f);
    check_val("ifence,illegal,wen", 3'b100,
              {got.sys.ifence, got.fields.illegal, got.fields.wen});
    // load_fp, vector and a stray funct7 bit
    issue_and_return(i_type(12'h010, 5'd1, 3'b010, 5'd2, 7'b0000111));
    check_val("illegal", 1, got.fields.illegal);
    issue_and_return(i_type(12'h000, 5'd1, 3'b111, 5'd2, 7'b1010111));
    check_val("illegal", 1, got.fields.illegal);
    issue_and_return(r_type(7'h03, 5'd1, 5'd2, 3'b000, 5'd3));
    check_val("illegal", 1, got.fields.illegal);
    finish_test("system_and_illegal", err0);
  endtask

  task automatic credit_backpressure();
    int err0;
    err0 = errors;
    for (int i = 0; i < `DEC_CREDITS; i++) begin
      issue(i_type(12'(i), 5'd1, 3'b000, 5'd2, 7'b0010011));
    end
    @(negedge clk);
    instr_valid_i = 1'b1;
    instr_i       = i_type(12'h055, 5'd1, 3'b000, 5'd2, 7'b0010011);
    repeat (5) begin
      @(negedge clk);
      check_val("instr_ready_o", 0, instr_ready_o);
      check_val("dispatch_valid_o", 0, dispatch_valid_o);
    end
    // one returned slot lets exactly one instruction through
    credit_return_i = 1'b1;
    @(negedge clk);
    credit_return_i = 1'b0;
    check_val("instr_ready_o", 1, instr_ready_o);
    @(negedge clk);
    check_val("dispatch_valid_o", 1, dispatch_valid_o);
    check_val("instr_ready_o", 0, instr_ready_o);
    repeat (3) begin
      @(negedge clk);
      check_val("instr_ready_o", 0, instr_ready_o);
      check_val("dispatch_valid_o", 0, dispatch_valid_o);
    end
    instr_valid_i = 1'b0;
    give_credit(`DEC_CREDITS);
    finish_test("credit_backpressure", err0);
  endtask

  task automatic controller_states();
    int    err0;
    word_t addi;
    err0 = errors;
    addi = i_type(12'h001, 5'd1, 3'b000, 5'd1, 7'b0010011);
    issue_and_return(32'h1050_0073);
    check_val("wfi", 1, got.sys.wfi);
    @(negedge clk);
    instr_valid_i = 1'b1;
    instr_i       = addi;
    repeat (5) begin
      @(negedge clk);
      check_val("instr_ready_o", 0, instr_ready_o);
    end
    instr_valid_i = 1'b0;
    irq_i         = 1'b1;
    @(negedge clk);
    irq_i = 1'b0;
    check_val("instr_ready_o", 1, instr_ready_o);
    issue_and_return(addi);
    issue(`DEC_HALT_INSN);
    check_val("jump,j_sel", 2'b11, {got.fields.jump, got.fields.j_sel});
    @(negedge clk);
    instr_valid_i   = 1'b1;
    instr_i         = addi;
    credit_return_i = 1'b1;
    repeat (8) begin
      @(negedge clk);
      check_val("instr_ready_o", !`DEC_HALT_EN, instr_ready_o);
    end
    instr_valid_i   = 1'b0;
    credit_return_i = 1'b0;
    finish_test("controller_states", err0);
  endtask

  initial begin
    #((NUM_INSTR * STEP_LIMIT + MARGIN) * 10);
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    clk             = 1'b0;
    rst_n_i         = 1'b0;
    instr_valid_i   = 1'b0;
    instr_i         = '0;
    credit_return_i = 1'b0;
    irq_i           = 1'b0;
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    void'($urandom(8540));
    repeat (3) @(negedge clk);
    rst_n_i = 1'b1;
    check_val("dispatch_valid_o", 0, dispatch_valid_o);
    check_val("instr_ready_o", 1, instr_ready_o);
    alu_instructions();
    memory_and_control();
    muldiv_routing();
    system_and_illegal();
    credit_backpressure();
    controller_states();
    // protocol assertions in the bound checker count as errors too
    errors = errors + decode_stage_i.decode_checker_i.violations;
    $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
